// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       := tb_dma_arb
FILELIST  := all.f
BUILD     := obj_dir
LOG       := sim.log
RUN_ARGS  := +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: all.f
verilog/dma_arb_pkg.sv
verilog/seq_queue.sv
verilog/dma_req_arbiter.sv
verilog/dma_beat_router.sv
verilog/dma_xfer_engine.sv
verilog/dma_arb_top.sv
bench/dma_arb_assert.sv
bench/dma_arb_checker.sv
bench/tb_dma_arb.sv

// File: bench/dma_arb_assert.sv
`timescale 1ns/1ps

module dma_arb_assert #(
    parameter int N_REGIONS = 4
) (
    input logic                 aclk,
    input logic                 aresetn,
    input logic [N_REGIONS-1:0] req_valid,
    input logic [N_REGIONS-1:0] req_ready,
    input logic                 xfer_valid,
    input logic [N_REGIONS-1:0] done
);

    // Count of failed assertions
    int unsigned fail_count = 0;

    // Only the chosen region sees ready
    one_ready: assert property (
        @(posedge aclk) disable iff (!aresetn) $onehot0(req_ready)
    ) else begin
        fail_count++;
        $error("more than one req_ready high: %b", req_ready);
    end

    // Completion returns to a single region
    one_done: assert property (
        @(posedge aclk) disable iff (!aresetn) $onehot0(done)
    ) else begin
        fail_count++;
        $error("more than one done high: %b", done);
    end

    // Engine request needs a region behind it
    valid_has_source: assert property (
        @(posedge aclk) disable iff (!aresetn) xfer_valid |-> (|req_valid)
    ) else begin
        fail_count++;
        $error("xfer_valid high with no req_valid");
    end

endmodule

bind dma_req_arbiter dma_arb_assert #(
    .N_REGIONS(N_REGIONS)
) u_assert (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .xfer_valid(xfer_valid),
    .done      (done)
);

// File: bench/dma_arb_checker.sv
`timescale 1ns/1ps

module dma_arb_checker import dma_arb_pkg::*; #(
    parameter int N_REGIONS = 4,
    parameter int DATA_BITS = 64
) (
    input  logic                                 aclk,
    input  logic                                 aresetn,
    input  logic [N_REGIONS-1:0]                 req_valid,
    input  logic [N_REGIONS-1:0]                 req_ready,
    input  logic [N_REGIONS-1:0][VADDR_BITS-1:0] req_vaddr,
    input  logic [N_REGIONS-1:0][LEN_BITS-1:0]   req_len,
    input  logic [N_REGIONS-1:0]                 req_ctl,
    input  logic [N_REGIONS-1:0]                 rd_valid,
    input  logic [DATA_BITS-1:0]                 rd_data,
    input  logic [N_REGIONS-1:0]                 done,
    output int unsigned                          mismatch_count,
    output int unsigned                          error_count,
    output logic                                 idle
);

    localparam int BEAT_BYTES = DATA_BITS / 8;
    localparam int BEAT_LOG   = $clog2(BEAT_BYTES);
    localparam int SHOW_BITS  = (DATA_BITS > 32) ? DATA_BITS : 32;

    // Expected beats per region, in grant order
    logic [DATA_BITS-1:0] exp_data [N_REGIONS][$];
    // Bit 1 holds the request's ctl and bit 0 marks its last beat
    logic [1:0]           exp_tag [N_REGIONS][$];
    // Regions owed a done pulse on the next edge
    logic [N_REGIONS-1:0] due_done = '0;
    int                   rr_ptr = 0;
    // Granted requests whose last beat has not been routed yet
    int                   inflight = 0;
    int                   busy_region = -1;
    bit                   after_reset = 1'b0;
    int unsigned          n_mismatch = 0;
    int unsigned          n_error = 0;

    assign mismatch_count = n_mismatch;
    assign error_count    = n_error;
    assign idle           = (inflight == 0) && (due_done == '0);

    // Reference beat count of a request
    function automatic int ref_nbeats(input logic [LEN_BITS-1:0] len);
        return ((int'(len) - 1) >> BEAT_LOG) + 1;
    endfunction

    // Reference payload of beat k is its own address zero-extended
    function automatic logic [DATA_BITS-1:0] ref_beat(input logic [VADDR_BITS-1:0] vaddr,
                                                      input int k);
        logic [VADDR_BITS-1:0] addr;
        addr = vaddr + VADDR_BITS'(k * BEAT_BYTES);
        return DATA_BITS'(addr);
    endfunction

    task automatic report_mismatch(input string test, input logic [SHOW_BITS-1:0] exp,
                                   input logic [SHOW_BITS-1:0] act);
        n_mismatch++;
        $display("mismatch %s: expected %0h actual %0h", test, exp, act);
    endtask

    task automatic report_error(input string what);
        n_error++;
        $display("error: %s", what);
    endtask

    task automatic check_reset();
        if (req_ready != '0 || rd_valid != '0 || done != '0) begin
            report_error($sformatf("outputs not low around reset, req_ready %b rd_valid %b done %b",
                                   req_ready, rd_valid, done));
        end
    endtask

    // Done is due one edge after the last beat of a ctl request
    task automatic check_done();
        if (done !== due_done) begin
            report_mismatch("completion", SHOW_BITS'(due_done), SHOW_BITS'(done));
        end
        due_done = '0;
    endtask

    task automatic check_beats();
        logic [DATA_BITS-1:0] exp;
        logic [1:0]           tag;
        if ($countones(rd_valid) > 1) begin
            report_error($sformatf("rd_valid high for several regions: %b", rd_valid));
        end
        for (int r = 0; r < N_REGIONS; r++) begin
            if (rd_valid[r]) begin
                // Beats of one request must not be split by another
                if (busy_region >= 0 && busy_region != r) begin
                    report_error($sformatf("beat for region %0d inside a transfer of region %0d",
                                           r, busy_region));
                end
                if (exp_data[r].size() == 0) begin
                    report_error($sformatf("beat for region %0d with nothing outstanding", r));
                end else begin
                    exp = exp_data[r].pop_front();
                    tag = exp_tag[r].pop_front();
                    if (rd_data !== exp) begin
                        report_mismatch("beat_data", SHOW_BITS'(exp), SHOW_BITS'(rd_data));
                    end
                    if (tag[0]) begin
                        busy_region = -1;
                        inflight--;
                        due_done[r] = tag[1];
                    end else begin
                        busy_region = r;
                    end
                end
            end
        end
    endtask

    task automatic check_grant();
        logic [N_REGIONS-1:0] granted;
        int                   exp_id;
        int                   act_id;
        int                   idx;
        int                   n;
        granted = req_valid & req_ready;
        if (granted != '0) begin
            exp_id = -1;
            act_id = -1;
            // First valid region at or after the pointer
            for (int k = 0; k < N_REGIONS; k++) begin
                idx = (rr_ptr + k) % N_REGIONS;
                if (exp_id < 0 && req_valid[idx]) begin
                    exp_id = idx;
                end
                if (granted[k]) begin
                    act_id = k;
                end
            end
            if ($countones(granted) > 1) begin
                report_error($sformatf("several requests accepted in one cycle: %b", granted));
            end
            if (act_id != exp_id) begin
                report_mismatch("round_robin", SHOW_BITS'(exp_id), SHOW_BITS'(act_id));
            end
            if (inflight > 0) begin
                report_error($sformatf("region %0d accepted while a transfer is still streaming",
                                       act_id));
            end
            n = ref_nbeats(req_len[act_id]);
            for (int k = 0; k < n; k++) begin
                exp_data[act_id].push_back(ref_beat(req_vaddr[act_id], k));
                exp_tag[act_id].push_back({req_ctl[act_id], k == n - 1});
            end
            inflight++;
            rr_ptr = (rr_ptr + 1) % N_REGIONS;
        end
    endtask

    // Beats are checked before grants since a grant may share the edge of the last beat
    always @(posedge aclk) begin
        if (!aresetn || after_reset) begin
            check_reset();
        end
        after_reset = !aresetn;
        if (aresetn) begin
            check_done();
            check_beats();
            check_grant();
        end
    end

endmodule

// File: bench/tb_dma_arb.sv
`timescale 1ns/1ps

module tb_dma_arb import dma_arb_pkg::*; ();

    localparam int N_REGIONS = 4;
    localparam int DATA_BITS = 64;
    localparam int N_REQ     = 40;
    localparam int MAX_BEATS = 64 / (DATA_BITS / 8);
    // Longest request plus handshake and completion per grant with margin on top
    localparam int TIMEOUT_CYCLES = N_REQ * (MAX_BEATS + 4) + 200;

    logic                                 aclk;
    logic                                 aresetn;
    logic [N_REGIONS-1:0]                 req_valid;
    logic [N_REGIONS-1:0]                 req_ready;
    logic [N_REGIONS-1:0][VADDR_BITS-1:0] req_vaddr;
    logic [N_REGIONS-1:0][LEN_BITS-1:0]   req_len;
    logic [N_REGIONS-1:0]                 req_ctl;
    logic [N_REGIONS-1:0]                 rd_valid;
    logic [DATA_BITS-1:0]                 rd_data;
    logic [N_REGIONS-1:0]                 done;

    int unsigned mismatch_count;
    int unsigned error_count;
    logic        chk_idle;
    logic [31:0] lfsr_state;
    int          raised_total;
    int          accepted_total;
    int          cycle_count;

    dma_arb_top #(
        .N_REGIONS(N_REGIONS),
        .DATA_BITS(DATA_BITS)
    ) DUT (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req_vaddr(req_vaddr),
        .req_len  (req_len),
        .req_ctl  (req_ctl),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .done     (done)
    );

    dma_arb_checker #(
        .N_REGIONS(N_REGIONS),
        .DATA_BITS(DATA_BITS)
    ) u_checker (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_vaddr     (req_vaddr),
        .req_len       (req_len),
        .req_ctl       (req_ctl),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data),
        .done          (done),
        .mismatch_count(mismatch_count),
        .error_count   (error_count),
        .idle          (chk_idle)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #20 aclk = ~aclk;
        end
    end

    // Galois LFSR stepped once for each bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[31:1]} ^
                         (lfsr_state[0] ? 32'h80200003 : 32'h0);
        end
        return bits;
    endfunction

    // Drop accepted requests and maybe raise new ones on idle regions
    task automatic drive_requests(input logic [N_REGIONS-1:0] taken);
        logic [31:0] bits;
        for (int r = 0; r < N_REGIONS; r++) begin
            if (taken[r]) begin
                req_valid[r] = 1'b0;
                accepted_total++;
            end
            if (!req_valid[r] && raised_total < N_REQ) begin
                bits = lfsr_bits(1);
                if (bits[0]) begin
                    // Length 1 to 64 bytes
                    bits = lfsr_bits(6);
                    req_len[r] = LEN_BITS'(bits[5:0]) + 1'b1;
                    bits = lfsr_bits(32);
                    req_vaddr[r] = bits;
                    bits = lfsr_bits(1);
                    req_ctl[r]   = bits[0];
                    req_valid[r] = 1'b1;
                    raised_total++;
                end
            end
        end
    endtask

    function automatic int unsigned total_errors();
        return mismatch_count + error_count + DUT.u_arbiter.u_assert.fail_count;
    endfunction

    task automatic report_counts();
        $display("checks done: %0d mismatches, %0d other errors, %0d assertion failures",
                 mismatch_count, error_count, DUT.u_arbiter.u_assert.fail_count);
    endtask

    initial begin
        logic [N_REGIONS-1:0] taken;
        aresetn        = 1'b0;
        req_valid      = '0;
        req_vaddr      = '0;
        req_len        = '0;
        req_ctl        = '0;
        lfsr_state     = 32'hf6df7357;
        raised_total   = 0;
        accepted_total = 0;
        taken          = '0;
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        // Quiet cycle right after reset
        @(negedge aclk);
        while (accepted_total < N_REQ) begin
            drive_requests(taken);
            @(posedge aclk);
            taken = req_valid & req_ready;
            @(negedge aclk);
        end
        // Wait for the last beats and completions to drain
        while (!chk_idle) begin
            @(negedge aclk);
        end
        repeat (4) @(negedge aclk);
        report_counts();
        if (total_errors() == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("timeout: run still busy after %0d cycles", cycle_count);
        report_counts();
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: verilog/dma_arb_pkg.sv
package dma_arb_pkg;

    // Widths shared by the arbiter, router and engine

    // Request byte length
    // Beat count minus one is derived from this in each block
    localparam int LEN_BITS = 16;

    // Virtual address of a request
    localparam int VADDR_BITS = 32;

    // Entries in the mux and completion sequence queues
    // Bounds the number of grants in flight ahead of the router
    localparam int QUEUE_DEPTH = 8;

    // Transfer engine states
    // idle accepts a new request, stream emits its beats
    typedef enum logic {
        idle,
        stream
    } xfer_state_t;

endpackage

// File: verilog/dma_arb_top.sv
`timescale 1ns/1ps

module dma_arb_top import dma_arb_pkg::*; #(
    parameter int N_REGIONS = 4,
    parameter int DATA_BITS = 64
) (
    input  logic                                 aclk,
    input  logic                                 aresetn,
    input  logic [N_REGIONS-1:0]                 req_valid,
    output logic [N_REGIONS-1:0]                 req_ready,
    input  logic [N_REGIONS-1:0][VADDR_BITS-1:0] req_vaddr,
    input  logic [N_REGIONS-1:0][LEN_BITS-1:0]   req_len,
    input  logic [N_REGIONS-1:0]                 req_ctl,
    output logic [N_REGIONS-1:0]                 rd_valid,
    output logic [DATA_BITS-1:0]                 rd_data,
    output logic [N_REGIONS-1:0]                 done
);

    localparam int ID_BITS  = (N_REGIONS > 1) ? $clog2(N_REGIONS) : 1;
    localparam int NTR_BITS = LEN_BITS - $clog2(DATA_BITS / 8);

    // Arbiter to engine request channel
    logic                  xfer_valid;
    logic                  xfer_ready;
    logic [VADDR_BITS-1:0] xfer_vaddr;
    logic [LEN_BITS-1:0]   xfer_len;
    logic                  xfer_ctl;
    logic                  xfer_done;
    // Engine beats
    logic                  beat_valid;
    logic [DATA_BITS-1:0]  beat_data;
    // Mux sequence head into the router
    logic                  seq_valid;
    logic                  seq_ready;
    logic [ID_BITS-1:0]    seq_id;
    logic [NTR_BITS-1:0]   seq_ntr;

    dma_req_arbiter #(
        .N_REGIONS(N_REGIONS),
        .DATA_BITS(DATA_BITS)
    ) u_arbiter (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_vaddr (req_vaddr),
        .req_len   (req_len),
        .req_ctl   (req_ctl),
        .xfer_valid(xfer_valid),
        .xfer_ready(xfer_ready),
        .xfer_vaddr(xfer_vaddr),
        .xfer_len  (xfer_len),
        .xfer_ctl  (xfer_ctl),
        .xfer_done (xfer_done),
        .seq_valid (seq_valid),
        .seq_ready (seq_ready),
        .seq_id    (seq_id),
        .seq_ntr   (seq_ntr),
        .done      (done)
    );

    dma_xfer_engine #(
        .DATA_BITS(DATA_BITS)
    ) u_engine (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .xfer_valid(xfer_valid),
        .xfer_ready(xfer_ready),
        .xfer_vaddr(xfer_vaddr),
        .xfer_len  (xfer_len),
        .xfer_ctl  (xfer_ctl),
        .beat_valid(beat_valid),
        .beat_data (beat_data),
        .xfer_done (xfer_done)
    );

    dma_beat_router #(
        .N_REGIONS(N_REGIONS),
        .DATA_BITS(DATA_BITS)
    ) u_router (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .seq_valid (seq_valid),
        .seq_ready (seq_ready),
        .seq_id    (seq_id),
        .seq_ntr   (seq_ntr),
        .beat_valid(beat_valid),
        .beat_data (beat_data),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

endmodule

// File: verilog/dma_beat_router.sv
`timescale 1ns/1ps

module dma_beat_router import dma_arb_pkg::*; #(
    parameter int N_REGIONS = 4,
    parameter int DATA_BITS = 64
) (
    input  logic                                    aclk,
    input  logic                                    aresetn,
    input  logic                                    seq_valid,
    output logic                                    seq_ready,
    input  logic [((N_REGIONS > 1) ? $clog2(N_REGIONS) : 1)-1:0] seq_id,
    input  logic [LEN_BITS-$clog2(DATA_BITS/8)-1:0] seq_ntr,
    input  logic                                    beat_valid,
    input  logic [DATA_BITS-1:0]                    beat_data,
    output logic [N_REGIONS-1:0]                    rd_valid,
    output logic [DATA_BITS-1:0]                    rd_data
);

    localparam int BEAT_LOG = $clog2(DATA_BITS / 8);
    localparam int NTR_BITS = LEN_BITS - BEAT_LOG;

    // Beats already routed for the head entry
    logic [NTR_BITS-1:0]  beat_cnt;
    logic                 last_beat;
    logic [N_REGIONS-1:0] rd_valid_r;
    logic [DATA_BITS-1:0] rd_data_r;

    assign last_beat = (beat_cnt == seq_ntr);

    // Pop on the last beat of the head entry
    assign seq_ready = beat_valid & seq_valid & last_beat;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            beat_cnt   <= '0;
            rd_valid_r <= '0;
        end else begin
            rd_valid_r <= '0;
            if (beat_valid && seq_valid) begin
                // One-hot to the head region
                rd_valid_r[seq_id] <= 1'b1;
                beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    // Data is shared by all regions
    always_ff @(posedge aclk) begin
        if (beat_valid) begin
            rd_data_r <= beat_data;
        end
    end

    assign rd_valid = rd_valid_r;
    assign rd_data  = rd_data_r;

endmodule

// File: verilog/dma_req_arbiter.sv
`timescale 1ns/1ps

module dma_req_arbiter import dma_arb_pkg::*; #(
    parameter int N_REGIONS = 4,
    parameter int DATA_BITS = 64
) (
    input  logic                                    aclk,
    input  logic                                    aresetn,
    input  logic [N_REGIONS-1:0]                    req_valid,
    output logic [N_REGIONS-1:0]                    req_ready,
    input  logic [N_REGIONS-1:0][VADDR_BITS-1:0]    req_vaddr,
    input  logic [N_REGIONS-1:0][LEN_BITS-1:0]      req_len,
    input  logic [N_REGIONS-1:0]                    req_ctl,
    output logic                                    xfer_valid,
    input  logic                                    xfer_ready,
    output logic [VADDR_BITS-1:0]                   xfer_vaddr,
    output logic [LEN_BITS-1:0]                     xfer_len,
    output logic                                    xfer_ctl,
    input  logic                                    xfer_done,
    output logic                                    seq_valid,
    input  logic                                    seq_ready,
    output logic [((N_REGIONS > 1) ? $clog2(N_REGIONS) : 1)-1:0] seq_id,
    output logic [LEN_BITS-$clog2(DATA_BITS/8)-1:0] seq_ntr,
    output logic [N_REGIONS-1:0]                    done
);

    localparam int ID_BITS  = (N_REGIONS > 1) ? $clog2(N_REGIONS) : 1;
    localparam int BEAT_LOG = $clog2(DATA_BITS / 8);
    localparam int NTR_BITS = LEN_BITS - BEAT_LOG;

    logic [ID_BITS-1:0]  rr_ptr;
    logic [ID_BITS-1:0]  grant_id;
    logic                found;
    logic                queues_ok;
    logic                accept;
    logic [LEN_BITS-1:0] len_m1;
    logic                mux_in_ready;
    logic                cpl_in_ready;
    logic                cpl_valid;
    logic [ID_BITS-1:0]  cpl_id;
    logic [N_REGIONS-1:0] done_r;

    // Rotating priority search from rr_ptr upward
    always_comb begin
        int unsigned idx;
        found    = 1'b0;
        grant_id = rr_ptr;
        for (int k = 0; k < N_REGIONS; k++) begin
            idx = int'(rr_ptr) + k;
            // Wrap past the last region
            if (idx >= N_REGIONS) begin
                idx = idx - N_REGIONS;
            end
            if (!found && req_valid[idx]) begin
                found    = 1'b1;
                grant_id = ID_BITS'(idx);
            end
        end
    end

    // A grant needs room in both sequence queues
    assign queues_ok  = mux_in_ready & cpl_in_ready;
    assign xfer_valid = found & queues_ok;
    assign accept     = xfer_valid & xfer_ready;

    always_comb begin
        req_ready = '0;
        req_ready[grant_id] = found & queues_ok & xfer_ready;
    end

    // Granted request onto the engine channel
    assign xfer_vaddr = req_vaddr[grant_id];
    assign xfer_len   = req_len[grant_id];
    assign xfer_ctl   = req_ctl[grant_id];

    // Beats minus one
    assign len_m1 = req_len[grant_id] - 1'b1;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rr_ptr <= '0;
            done_r <= '0;
        end else begin
            // Pointer steps by one per grant and does not skip past the winner
            if (accept) begin
                rr_ptr <= (rr_ptr == ID_BITS'(N_REGIONS - 1)) ? '0 : rr_ptr + 1'b1;
            end
            done_r <= '0;
            if (xfer_done && cpl_valid) begin
                done_r[cpl_id] <= 1'b1;
            end
        end
    end

    assign done = done_r;

    // Mux sequence of region id and beat count for the router
    seq_queue #(
        .WIDTH(ID_BITS + NTR_BITS),
        .DEPTH(QUEUE_DEPTH)
    ) u_mux_queue (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .in_valid (accept),
        .in_ready (mux_in_ready),
        .in_data  ({grant_id, len_m1[LEN_BITS-1:BEAT_LOG]}),
        .out_valid(seq_valid),
        .out_ready(seq_ready),
        .out_data ({seq_id, seq_ntr})
    );

    // Completion sequence that only ctl requests enter
    seq_queue #(
        .WIDTH(ID_BITS),
        .DEPTH(QUEUE_DEPTH)
    ) u_cpl_queue (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .in_valid (accept & req_ctl[grant_id]),
        .in_ready (cpl_in_ready),
        .in_data  (grant_id),
        .out_valid(cpl_valid),
        .out_ready(xfer_done),
        .out_data (cpl_id)
    );

endmodule

// File: verilog/dma_xfer_engine.sv
`timescale 1ns/1ps

module dma_xfer_engine import dma_arb_pkg::*; #(
    parameter int DATA_BITS = 64
) (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  xfer_valid,
    output logic                  xfer_ready,
    input  logic [VADDR_BITS-1:0] xfer_vaddr,
    input  logic [LEN_BITS-1:0]   xfer_len,
    input  logic                  xfer_ctl,
    output logic                  beat_valid,
    output logic [DATA_BITS-1:0]  beat_data,
    output logic                  xfer_done
);

    localparam int BEAT_LOG   = $clog2(DATA_BITS / 8);
    localparam int NTR_BITS   = LEN_BITS - BEAT_LOG;
    localparam int BEAT_BYTES = DATA_BITS / 8;

    xfer_state_t           state;
    logic [NTR_BITS-1:0]   beats_left;
    logic [VADDR_BITS-1:0] beat_addr;
    logic                  ctl_q;
    logic                  done_r;
    logic [LEN_BITS-1:0]   len_m1;

    // One request at a time
    assign xfer_ready = (state == idle);
    assign len_m1     = xfer_len - 1'b1;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state      <= idle;
            beats_left <= '0;
            beat_addr  <= '0;
            ctl_q      <= 1'b0;
            done_r     <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (state)
                idle: begin
                    if (xfer_valid) begin
                        // Latch request, first beat next cycle
                        beat_addr  <= xfer_vaddr;
                        beats_left <= len_m1[LEN_BITS-1:BEAT_LOG];
                        ctl_q      <= xfer_ctl;
                        state      <= stream;
                    end
                end
                stream: begin
                    beat_addr <= beat_addr + VADDR_BITS'(BEAT_BYTES);
                    if (beats_left == '0) begin
                        // Done lands with the return to idle
                        done_r <= ctl_q;
                        state  <= idle;
                    end else begin
                        beats_left <= beats_left - 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Beat payload is the address of the beat, zero-extended
    assign beat_valid = (state == stream);
    assign beat_data  = DATA_BITS'(beat_addr);
    assign xfer_done  = done_r;

endmodule

// File: verilog/seq_queue.sv
`timescale 1ns/1ps

module seq_queue #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8
) (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    // Entry storage with its pointers and occupancy
    logic [WIDTH-1:0]    mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                push;
    logic                pop;

    assign in_ready  = (count != CNT_BITS'(DEPTH));
    assign out_valid = (count != '0);
    // Head is read straight from the array
    assign out_data  = mem[rd_ptr];

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap at DEPTH so any depth works
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule
